// ==== bench/rsv_issue_vectors.svh ====
// Stimulus table for the issue slice
// Columns are name, op, dest, src1, src2 or imm, expected value and idle gap before row
`ifndef RSV_ISSUE_VECTORS_SVH
`define RSV_ISSUE_VECTORS_SVH

// Row index is the rob tag and every dest is a fresh physical register
task automatic load_vectors();
    // Immediate decode, wakeup, out-of-order and same-cycle bypass
    queue_imm_op("addi_neg",        ADD,  1,  0,     -5, 32'hFFFF_FFFB, 1'b1);
    queue_reg_op("add_both_wait",   ADD,  2,  1,      1, 32'hFFFF_FFF6, 1'b0);
    queue_imm_op("ori_pos",         OR,   3,  0,   1000, 32'h0000_03E8, 1'b0);
    queue_reg_op("xor_one_wait",    XOR,  4,  1,      3, 32'hFFFF_FC13, 1'b0);
    queue_imm_op("xori_min",        XOR,  5,  0, -16384, 32'hFFFF_C000, 1'b0);
    queue_reg_op("slt_bypass",      SLT,  6,  1,      3, 32'h0000_0001, 1'b0);

    // Slow dependent chain with one link per op
    queue_reg_op("chain_sub",       SUB,  7,  3,      2, 32'h0000_03F2, 1'b1);
    queue_reg_op("chain_sll",       SLL,  8,  7,      6, 32'h0000_07E4, 1'b0);
    queue_reg_op("chain_and",       AND,  9,  8,      4, 32'h0000_0400, 1'b0);
    queue_reg_op("chain_or",        OR,  10,  9,      5, 32'hFFFF_C400, 1'b0);
    queue_reg_op("chain_srl",       SRL, 11, 10,      7, 32'h0000_3FFF, 1'b0);
    queue_reg_op("chain_xor",       XOR, 12, 11,      2, 32'hFFFF_C009, 1'b0);
    queue_reg_op("chain_slt",       SLT, 13, 12,      1, 32'h0000_0001, 1'b0);
    queue_reg_op("chain_sub_wrap",  SUB, 14, 13,      5, 32'h0000_4001, 1'b0);

    // Burst on the chain end that fills the station
    queue_reg_op("burst_add_self",  ADD, 15, 14,     14, 32'h0000_8002, 1'b0);
    queue_reg_op("burst_add_wrap",  ADD, 16, 14,      1, 32'h0000_3FFC, 1'b0);
    queue_reg_op("burst_sub",       SUB, 17, 14,      3, 32'h0000_3C19, 1'b0);
    queue_reg_op("burst_sub_neg",   SUB, 18,  3,     14, 32'hFFFF_C3E7, 1'b0);
    queue_reg_op("burst_and",       AND, 19, 14,      5, 32'h0000_4000, 1'b0);
    queue_reg_op("burst_or",        OR,  20, 14,      3, 32'h0000_43E9, 1'b0);
    queue_reg_op("burst_xor_self",  XOR, 21, 14,     14, 32'h0000_0000, 1'b0);
    queue_reg_op("burst_sll_31",    SLL, 22, 14,     11, 32'h8000_0000, 1'b0);
    queue_reg_op("burst_sll_amt",   SLL, 23,  5,     14, 32'hFFFF_8000, 1'b0);
    queue_reg_op("burst_srl_zero",  SRL, 24, 14,      9, 32'h0000_4001, 1'b0);
    queue_reg_op("burst_srl_neg",   SRL, 25,  2,     14, 32'h7FFF_FFFB, 1'b0);
    queue_reg_op("burst_slt_false", SLT, 26, 14,      3, 32'h0000_0000, 1'b0);
    queue_reg_op("burst_slt_true",  SLT, 27,  1,     14, 32'h0000_0001, 1'b0);
    queue_reg_op("burst_slt_self",  SLT, 28, 14,     14, 32'h0000_0000, 1'b0);
    queue_imm_op("burst_addi_neg",  ADD, 29, 14,     -1, 32'h0000_4000, 1'b0);
    queue_imm_op("burst_xori",      XOR, 30, 14,  16'h7FF, 32'h0000_47FE, 1'b0);
    // These two wait for a free slot
    queue_reg_op("burst_add_late",  ADD, 31, 14,     12, 32'h0000_000A, 1'b1);
    queue_imm_op("burst_ori_late",  OR,  32, 14,     -2, 32'hFFFF_FFFF, 1'b0);
endtask

`endif

// ==== bench/tb_rsv_issue.sv ====
// Issue slice testbench
`timescale 1ns/100ps
`default_nettype none

module tb_rsv_issue;
    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 instr_valid;
    instr_u               instr;
    logic [ROB_TAG_W-1:0] rob_tag;
    logic                 full;
    logic                 complete_valid;
    result_t              complete;

    // Stimulus table with one entry per row
    string                names [$];
    instr_u               words [$];
    logic [XLEN-1:0]      expects [$];
    bit                   gaps [$];

    bit                   completed [2**ROB_TAG_W];
    bit                   saw_full = 1'b0;
    int                   done_count = 0;
    int                   passes = 0;
    int                   errors = 0;
    integer               seed;

    rsv_issue_top dut_i (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .rob_tag(rob_tag), .full(full), .complete_valid(complete_valid),
        .complete(complete)
    );

    always #10 clk = ~clk;

    task automatic append_row(input string name, input instr_u w,
                              input logic [XLEN-1:0] value, input bit gap);
        names.push_back(name);
        words.push_back(w);
        expects.push_back(value);
        gaps.push_back(gap);
    endtask

    task automatic queue_reg_op(input string name, input alu_op_e op, input int dest,
                                input int src1, input int src2,
                                input logic [XLEN-1:0] value, input bit gap);
        instr_u w;
        w = '0;
        w.r.op = op;
        w.r.is_imm = 1'b0;
        w.r.dest = PREG_W'(dest);
        w.r.src1 = PREG_W'(src1);
        w.r.src2 = PREG_W'(src2);
        append_row(name, w, value, gap);
    endtask

    task automatic queue_imm_op(input string name, input alu_op_e op, input int dest,
                                input int src1, input int imm,
                                input logic [XLEN-1:0] value, input bit gap);
        instr_u w;
        w = '0;
        w.i.op = op;
        w.i.is_imm = 1'b1;
        w.i.dest = PREG_W'(dest);
        w.i.src1 = PREG_W'(src1);
        w.i.imm = IMM_W'(imm);
        append_row(name, w, value, gap);
    endtask

    `include "rsv_issue_vectors.svh"

    task automatic check_result(input string name, input result_t expected,
                                input result_t actual);
        if (actual === expected) begin
            passes++;
            $display("PASS %s: tag %0d dest %0d value %h",
                     name, actual.rob_tag, actual.dest, actual.value);
        end else begin
            errors++;
            $display("Mismatch %s: expected tag %0d dest %0d %h, actual tag %0d dest %0d %h",
                     name, expected.rob_tag, expected.dest, expected.value,
                     actual.rob_tag, actual.dest, actual.value);
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            passes++;
            $display("PASS %s: %b", name, actual);
        end else begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic record_completion(input result_t actual);
        int      tag;
        result_t expected;
        tag = int'(actual.rob_tag);
        if (completed[tag]) begin
            errors++;
            $display("Rob tag %0d (%s) completed a second time", tag, names[tag]);
        end else begin
            completed[tag] = 1'b1;
            done_count++;
            expected.rob_tag = ROB_TAG_W'(tag);
            expected.dest = words[tag].r.dest;
            expected.value = expects[tag];
            check_result(names[tag], expected, actual);
        end
    endtask

    // Starts at a falling edge and holds off while the station is full
    task automatic issue_row(input int row);
        while (full) begin
            instr_valid = 1'b0;
            @(negedge clk);
        end
        instr_valid = 1'b1;
        instr = words[row];
        rob_tag = ROB_TAG_W'(row);
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // Outputs settle mid-cycle
    always @(negedge clk) begin
        if (rst_n === 1'b1 && full === 1'b1) begin
            saw_full = 1'b1;
        end
        if (rst_n === 1'b1 && complete_valid === 1'b1) begin
            record_completion(complete);
        end
    end

    initial begin : watchdog
        int limit;
        int cycles;
        @(posedge clk);
        limit = 8 * words.size() + 100;
        cycles = 1;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d rows completed",
                 cycles, done_count, words.size());
        for (int row = 0; row < words.size(); row++) begin
            if (!completed[row]) begin
                $display("Row %0d (%s) never completed", row, names[row]);
            end
        end
        $display("Checks failed");
        $finish;
    end

    initial begin
        int idle;
        seed = 64531;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        rob_tag = '0;
        load_vectors();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_level("full_after_reset", 1'b0, full);
        check_level("complete_idle_after_reset", 1'b0, complete_valid);

        for (int row = 0; row < words.size(); row++) begin
            if (gaps[row]) begin
                idle = $random(seed) & 7;
                repeat (idle) @(negedge clk);
            end
            issue_row(row);
        end

        wait (done_count == words.size());
        // Room for a stray second completion to show up
        repeat (4) @(negedge clk);
        #5;
        check_level("station_full_seen", 1'b1, saw_full);
        $display("Summary: %0d passed, %0d errors, %0d of %0d rows completed",
                 passes, errors, done_count, words.size());
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/alu_exec.sv ====
// Integer ALU with one registered stage
`timescale 1ns/100ps
`default_nettype none

module alu_exec (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    issue_valid,
    input  wire uop_pkg::issue_t   issue,
    output logic                   alu_valid,
    output uop_pkg::result_t       alu_result
);
    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic [XLEN-1:0] value;

    always_comb begin
        case (issue.op)
            ADD:     value = issue.rs1 + issue.rs2;
            SUB:     value = issue.rs1 - issue.rs2;
            AND:     value = issue.rs1 & issue.rs2;
            OR:      value = issue.rs1 | issue.rs2;
            XOR:     value = issue.rs1 ^ issue.rs2;
            SLL:     value = issue.rs1 << issue.rs2[4:0];
            SRL:     value = issue.rs1 >> issue.rs2[4:0];
            SLT:     value = ($signed(issue.rs1) < $signed(issue.rs2)) ? XLEN'(1) : '0;
            default: value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid;
        end
    end

    // Result payload follows the valid strobe
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            alu_result.rob_tag <= issue.rob_tag;
            alu_result.dest    <= issue.dest;
            alu_result.value   <= value;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/core_cfg_pkg.sv ====
// Core sizing constants
`default_nettype none

package core_cfg_pkg;

    // Datapath
    localparam int XLEN      = 32;
    localparam int IMM_W     = 15;

    // Physical register file
    localparam int PHYS_REGS = 64;
    localparam int PREG_W    = 6;

    // Reorder buffer tag
    localparam int ROB_TAG_W = 5;

    // Reservation station
    localparam int RSV_SIZE  = 16;
    localparam int RSV_IDX_W = 4;

endpackage

`default_nettype wire

// ==== hdl/result_wb.sv ====
// Physical register file and result broadcast
`timescale 1ns/100ps
`default_nettype none

module result_wb (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  alu_valid,
    input  wire uop_pkg::result_t                alu_result,
    input  wire                                  alloc_valid,
    input  wire [core_cfg_pkg::PREG_W-1:0]       alloc_dest,
    input  wire [core_cfg_pkg::PREG_W-1:0]       src1_reg,
    input  wire [core_cfg_pkg::PREG_W-1:0]       src2_reg,
    output logic [core_cfg_pkg::XLEN-1:0]        src1_value,
    output logic                                 src1_ready,
    output logic [core_cfg_pkg::XLEN-1:0]        src2_value,
    output logic                                 src2_ready,
    output logic                                 bcast_valid,
    output uop_pkg::result_t                     bcast
);
    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic [XLEN-1:0]      regs [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready_bits;

    // Ready flag and value with broadcast bypass
    function automatic logic [XLEN:0] read_port(input logic [PREG_W-1:0] rd);
        if (bcast_valid && bcast.dest == rd) begin
            return {1'b1, bcast.value};
        end
        return {ready_bits[rd], regs[rd]};
    endfunction

    assign bcast_valid = alu_valid;
    assign bcast       = alu_result;

    always_comb begin
        {src1_ready, src1_value} = read_port(src1_reg);
        {src2_ready, src2_value} = read_port(src2_reg);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_bits <= '1;
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (bcast_valid) begin
                regs[bcast.dest]       <= bcast.value;
                ready_bits[bcast.dest] <= 1'b1;
            end
            // A newer producer renamed onto the same register wins
            if (alloc_valid) begin
                ready_bits[alloc_dest] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rsv.sv ====
// Reservation station
`timescale 1ns/100ps
`default_nettype none

module rsv (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    alloc_valid,
    input  wire uop_pkg::uop_t     uop,
    input  wire                    bcast_valid,
    input  wire uop_pkg::result_t  bcast,
    output logic                   full,
    output logic                   issue_valid,
    output uop_pkg::issue_t        issue
);
    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic [RSV_SIZE-1:0]  free_list;
    logic [RSV_SIZE-1:0]  ready;
    rsv_entry_t           entries [RSV_SIZE];
    rsv_entry_t           alloc_entry;
    logic [RSV_IDX_W:0]   alloc_sel;
    logic [RSV_IDX_W:0]   disp_sel;
    logic                 alloc_found;
    logic                 disp_found;
    logic [RSV_IDX_W-1:0] alloc_idx;
    logic [RSV_IDX_W-1:0] disp_idx;
    logic                 alloc_fire;

    // Lowest set bit with a hit flag in the MSB
    function automatic logic [RSV_IDX_W:0] lowest_set(input logic [RSV_SIZE-1:0] vec);
        logic [RSV_IDX_W:0] res;
        res = '0;
        for (int i = RSV_SIZE - 1; i >= 0; i--) begin
            if (vec[i]) begin
                res = {1'b1, RSV_IDX_W'(i)};
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < RSV_SIZE; i++) begin
            ready[i] = !free_list[i] && entries[i].src1_ready && entries[i].src2_ready;
        end
    end

    assign alloc_sel   = lowest_set(free_list);
    assign disp_sel    = lowest_set(ready);
    assign alloc_found = alloc_sel[RSV_IDX_W];
    assign alloc_idx   = alloc_sel[RSV_IDX_W-1:0];
    assign disp_found  = disp_sel[RSV_IDX_W];
    assign disp_idx    = disp_sel[RSV_IDX_W-1:0];

    assign full       = !alloc_found;
    assign alloc_fire = alloc_valid && alloc_found;

    // Incoming uop also catches a broadcast in its allocate cycle
    always_comb begin
        alloc_entry = uop;
        if (bcast_valid && !uop.src1_ready && uop.src1_reg == bcast.dest) begin
            alloc_entry.src1_ready = 1'b1;
            alloc_entry.src1_value = bcast.value;
        end
        if (bcast_valid && !uop.src2_ready && uop.src2_reg == bcast.dest) begin
            alloc_entry.src2_ready = 1'b1;
            alloc_entry.src2_value = bcast.value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_list   <= '1;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= disp_found;
            if (disp_found) begin
                free_list[disp_idx] <= 1'b1;
            end
            if (alloc_fire) begin
                free_list[alloc_idx] <= 1'b0;
            end
        end
    end

    // Entry storage and wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < RSV_SIZE; i++) begin
            if (alloc_fire && alloc_idx == RSV_IDX_W'(i)) begin
                entries[i] <= alloc_entry;
            end else if (bcast_valid) begin
                if (!entries[i].src1_ready && entries[i].src1_reg == bcast.dest) begin
                    entries[i].src1_ready <= 1'b1;
                    entries[i].src1_value <= bcast.value;
                end
                if (!entries[i].src2_ready && entries[i].src2_reg == bcast.dest) begin
                    entries[i].src2_ready <= 1'b1;
                    entries[i].src2_value <= bcast.value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_found) begin
            issue.rob_tag <= entries[disp_idx].rob_tag;
            issue.op      <= entries[disp_idx].op;
            issue.dest    <= entries[disp_idx].dest;
            issue.rs1     <= entries[disp_idx].src1_value;
            issue.rs2     <= entries[disp_idx].src2_value;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rsv_issue_top.sv ====
// Out-of-order issue slice top
`timescale 1ns/100ps
`default_nettype none

module rsv_issue_top (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                instr_valid,
    input  wire uop_pkg::instr_u               instr,
    input  wire [core_cfg_pkg::ROB_TAG_W-1:0]  rob_tag,
    output logic                               full,
    output logic                               complete_valid,
    output uop_pkg::result_t                   complete
);
    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic [PREG_W-1:0] src1_reg;
    logic [PREG_W-1:0] src2_reg;
    logic [XLEN-1:0]   src1_value;
    logic [XLEN-1:0]   src2_value;
    logic              src1_ready;
    logic              src2_ready;
    uop_t              uop;
    logic              alloc_valid;
    logic              issue_valid;
    issue_t            issue;
    logic              alu_valid;
    result_t           alu_result;
    logic              bcast_valid;
    result_t           bcast;

    assign alloc_valid    = instr_valid && !full;
    assign complete_valid = bcast_valid;
    assign complete       = bcast;

    uop_decode decode_i (
        .instr(instr), .rob_tag(rob_tag),
        .src1_value(src1_value), .src1_ready(src1_ready),
        .src2_value(src2_value), .src2_ready(src2_ready),
        .src1_reg(src1_reg), .src2_reg(src2_reg), .uop(uop)
    );

    rsv rsv_i (
        .clk(clk), .rst_n(rst_n), .alloc_valid(alloc_valid), .uop(uop),
        .bcast_valid(bcast_valid), .bcast(bcast),
        .full(full), .issue_valid(issue_valid), .issue(issue)
    );

    alu_exec alu_i (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue(issue),
        .alu_valid(alu_valid), .alu_result(alu_result)
    );

    result_wb wb_i (
        .clk(clk), .rst_n(rst_n), .alu_valid(alu_valid), .alu_result(alu_result),
        .alloc_valid(alloc_valid), .alloc_dest(uop.dest),
        .src1_reg(src1_reg), .src2_reg(src2_reg),
        .src1_value(src1_value), .src1_ready(src1_ready),
        .src2_value(src2_value), .src2_ready(src2_ready),
        .bcast_valid(bcast_valid), .bcast(bcast)
    );

endmodule

`default_nettype wire

// ==== hdl/uop_decode.sv ====
// Instruction decode and operand fetch
`timescale 1ns/100ps
`default_nettype none

module uop_decode (
    input  wire uop_pkg::instr_u                 instr,
    input  wire [core_cfg_pkg::ROB_TAG_W-1:0]    rob_tag,
    input  wire [core_cfg_pkg::XLEN-1:0]         src1_value,
    input  wire                                  src1_ready,
    input  wire [core_cfg_pkg::XLEN-1:0]         src2_value,
    input  wire                                  src2_ready,
    output logic [core_cfg_pkg::PREG_W-1:0]      src1_reg,
    output logic [core_cfg_pkg::PREG_W-1:0]      src2_reg,
    output uop_pkg::uop_t                        uop
);
    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic            is_imm;
    logic [XLEN-1:0] imm_sext;

    // Top fields are shared by both views
    assign is_imm   = instr.r.is_imm;
    assign imm_sext = {{(XLEN-IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};

    // Register file read addresses
    assign src1_reg = instr.r.src1;
    assign src2_reg = is_imm ? '0 : instr.r.src2;

    always_comb begin
        uop.rob_tag    = rob_tag;
        uop.op         = instr.r.op;
        uop.dest       = instr.r.dest;
        uop.src1_reg   = instr.r.src1;
        uop.src1_ready = src1_ready;
        uop.src1_value = src1_value;

        if (is_imm) begin
            // Immediate operand needs no wakeup
            uop.src2_reg   = '0;
            uop.src2_ready = 1'b1;
            uop.src2_value = imm_sext;
        end else begin
            uop.src2_reg   = instr.r.src2;
            uop.src2_ready = src2_ready;
            uop.src2_value = src2_value;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uop_pkg.sv ====
// Instruction and micro-op types
`default_nettype none

package uop_pkg;
    import core_cfg_pkg::*;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SLT = 4'd7
    } alu_op_e;

    // Register form
    typedef struct packed {
        alu_op_e             op;
        logic                is_imm;
        logic [PREG_W-1:0]   dest;
        logic [PREG_W-1:0]   src1;
        logic [PREG_W-1:0]   src2;
        logic [8:0]          unused;
    } instr_r_t;

    // Immediate form with imm sign-extended on decode
    typedef struct packed {
        alu_op_e             op;
        logic                is_imm;
        logic [PREG_W-1:0]   dest;
        logic [PREG_W-1:0]   src1;
        logic [IMM_W-1:0]    imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic [ROB_TAG_W-1:0] rob_tag;
        alu_op_e              op;
        logic [PREG_W-1:0]    dest;
        logic [PREG_W-1:0]    src1_reg;
        logic                 src1_ready;
        logic [XLEN-1:0]      src1_value;
        logic [PREG_W-1:0]    src2_reg;
        logic                 src2_ready;
        logic [XLEN-1:0]      src2_value;
    } uop_t;

    typedef uop_t rsv_entry_t;

    typedef struct packed {
        logic [ROB_TAG_W-1:0] rob_tag;
        alu_op_e              op;
        logic [PREG_W-1:0]    dest;
        logic [XLEN-1:0]      rs1;
        logic [XLEN-1:0]      rs2;
    } issue_t;

    typedef struct packed {
        logic [ROB_TAG_W-1:0] rob_tag;
        logic [PREG_W-1:0]    dest;
        logic [XLEN-1:0]      value;
    } result_t;

endpackage

`default_nettype wire

// ==== rsv_issue.f ====
+incdir+bench
hdl/core_cfg_pkg.sv
hdl/uop_pkg.sv
hdl/uop_decode.sv
hdl/rsv.sv
hdl/alu_exec.sv
hdl/result_wb.sv
hdl/rsv_issue_top.sv
bench/tb_rsv_issue.sv
